/* mpu_consts.svh */
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// ==========================================================================
// address windows matched against adr[31:8]
// ==========================================================================
`define MPU_PIT_BASE 24'hFFDC11
`define MPU_PIC_BASE 24'hFFDC0F

// ==========================================================================
// timer registers
// ==========================================================================
// offsets inside one 16 byte channel block
// channel number comes from adr[5:4]
`define PIT_REG_RELOAD 4'h0
`define PIT_REG_COUNT  4'h4
`define PIT_REG_CTRL   4'h8

// control register bit positions
`define PIT_CTRL_EN   0
`define PIT_CTRL_AUTO 1

// ==========================================================================
// interrupt controller registers
// ==========================================================================
`define PIC_REG_PEND  8'h00
`define PIC_REG_EN    8'h04
`define PIC_REG_LVL   8'h08
`define PIC_REG_CAUSE 8'h0C

`endif

/* mpu_pkg.sv */
package mpu_pkg;

	// plain vectors
	typedef logic [31:0]  adr_t;
	typedef logic [127:0] dat128_t;
	typedef logic [31:0]  dat32_t;
	typedef logic [15:0]  sel16_t;
	typedef logic [3:0]   sel4_t;
	typedef logic [3:0]   irq_lvl_t;
	// interrupt source number
	typedef logic [7:0]   cause_t;

	// request driven by a 128-bit master
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		sel16_t  sel;
		adr_t    adr;
		dat128_t dat;
	} bus_req_t;

	// request as a 32-bit peripheral sees it
	typedef struct packed {
		logic   stb;
		logic   we;
		sel4_t  sel;
		adr_t   adr;
		dat32_t dat;
	} per_req_t;

	// bus controller transaction states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_DONE
	} bus_state_t;

	// expand byte selects into a bit mask for partial writes
	function automatic dat32_t sel_mask(input sel4_t sel);
		dat32_t m;
		for (int i = 0; i < 4; i++) begin
			m[i*8 +: 8] = {8{sel[i]}};
		end
		return m;
	endfunction

endpackage

/* mpu_bus_ctrl.sv */
`timescale 1ns/100ps
`include "mpu_consts.svh"

module mpu_bus_ctrl import mpu_pkg::*; (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  bus_req_t   m_req_i,
	output logic       m_ack_o,
	output dat128_t    m_dat_o,
	output bus_req_t   ext_req_o,
	input  logic       ext_ack_i,
	input  dat128_t    ext_dat_i,
	output bus_req_t   req_o,
	output logic       pit_stb_o,
	input  logic       pit_ack_i,
	input  dat32_t     pit_dat_i,
	output logic       pic_stb_o,
	input  logic       pic_ack_i,
	input  dat32_t     pic_dat_i
);

	bus_req_t   req_q;
	bus_state_t state_q;
	logic       ext_act_q;
	logic       hit_pit;
	logic       hit_pic;
	logic       ext_ack;
	logic       ack_any;

	// ======================================================================
	// request register
	// ======================================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_q <= '0;
		end else begin
			req_q <= m_req_i;
		end
	end

	assign req_o = req_q;

	// window decode on the upper 24 address bits
	assign hit_pit = (req_q.adr[31:8] == `MPU_PIT_BASE);
	assign hit_pic = (req_q.adr[31:8] == `MPU_PIC_BASE);

	// external ack only counts while our own cycle is out
	assign ext_ack = ext_act_q & ext_ack_i;
	assign ack_any = pit_ack_i | pic_ack_i | ext_ack;

	// ======================================================================
	// transaction FSM
	// ======================================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= ST_IDLE;
			pit_stb_o <= 1'b0;
			pic_stb_o <= 1'b0;
			ext_act_q <= 1'b0;
			m_ack_o   <= 1'b0;
		end else begin
			// peripheral strobes and master ack are single pulses
			pit_stb_o <= 1'b0;
			pic_stb_o <= 1'b0;
			m_ack_o   <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (req_q.cyc && req_q.stb) begin
						if (hit_pit) begin
							pit_stb_o <= 1'b1;
						end else if (hit_pic) begin
							pic_stb_o <= 1'b1;
						end else begin
							ext_act_q <= 1'b1;
						end
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// external bus may stall here as long as it likes
					if (ack_any) begin
						m_ack_o   <= 1'b1;
						ext_act_q <= 1'b0;
						state_q   <= ST_DONE;
					end
				end
				ST_DONE: begin
					// hold off until the master drops its strobe
					if (!req_q.stb) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// ======================================================================
	// read data return
	// ======================================================================
	// 32-bit peripheral data copied into all four lanes
	always_ff @(posedge clk_i) begin
		if (state_q == ST_WAIT) begin
			casez ({pic_ack_i, pit_ack_i, ext_ack})
				3'b1??: m_dat_o <= {4{pic_dat_i}};
				3'b01?: m_dat_o <= {4{pit_dat_i}};
				3'b001: m_dat_o <= ext_dat_i;
				default: m_dat_o <= m_dat_o;
			endcase
		end
	end

	// external request follows the registered request
	always_comb begin
		ext_req_o     = req_q;
		ext_req_o.cyc = ext_act_q;
		ext_req_o.stb = ext_act_q;
	end

endmodule

/* mpu_lane_steer.sv */
`timescale 1ns/100ps

module mpu_lane_steer import mpu_pkg::*; (
	input  bus_req_t req_i,
	output per_req_t per_o
);

	logic [3:0] nib_any;
	logic [1:0] lane;

	// one flag per 32-bit lane
	assign nib_any[0] = |req_i.sel[3:0];
	assign nib_any[1] = |req_i.sel[7:4];
	assign nib_any[2] = |req_i.sel[11:8];
	assign nib_any[3] = |req_i.sel[15:12];

	// rebuilt address bits 3:2
	// bytes 8..15 set a3, bytes 4..7 or 12..15 set a2
	// no selects at all falls back to lane 0
	assign lane[1] = nib_any[2] | nib_any[3];
	assign lane[0] = nib_any[1] | nib_any[3];

	always_comb begin
		// each peripheral gets its own strobe from the controller
		per_o.stb = 1'b0;
		per_o.we  = req_i.we;
		// fold the four select nibbles
		per_o.sel = req_i.sel[15:12] | req_i.sel[11:8] | req_i.sel[7:4] | req_i.sel[3:0];
		per_o.adr = {req_i.adr[31:4], lane, 2'b00};
		// write lane picked with the same bits as the address
		per_o.dat = req_i.dat[{lane, 5'b0} +: 32];
	end

endmodule

/* mpu_pit.sv */
`timescale 1ns/100ps
`include "mpu_consts.svh"

module mpu_pit import mpu_pkg::*; (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  logic       stb_i,
	input  per_req_t   per_i,
	output logic       ack_o,
	output dat32_t     dat_o,
	output logic [2:0] pit_out_o
);

	dat32_t     reload_r [3];
	dat32_t     count_r  [3];
	logic [2:0] en_r;
	logic [2:0] auto_r;
	logic [1:0] chan;
	logic [3:0] ofs;
	logic       wr;
	dat32_t     wmask;
	dat32_t     rd_dat;

	// channel from adr[5:4] and register within the block
	assign chan  = per_i.adr[5:4];
	assign ofs   = per_i.adr[3:0];
	assign wr    = stb_i & per_i.we;
	assign wmask = sel_mask(per_i.sel);

	// ======================================================================
	// timer channels
	// ======================================================================
	for (genvar g = 0; g < 3; g++) begin : g_chan
		dat32_t reload_q;
		dat32_t count_q;
		dat32_t reload_nxt;
		logic   en_q;
		logic   auto_q;
		logic   out_q;
		logic   wr_chan;

		assign wr_chan    = wr && (chan == 2'(g));
		assign reload_nxt = (reload_q & ~wmask) | (per_i.dat & wmask);

		always_ff @(posedge clk_i or negedge arst_n_i) begin
			if (!arst_n_i) begin
				reload_q <= '0;
				count_q  <= '0;
				en_q     <= 1'b0;
				auto_q   <= 1'b0;
				out_q    <= 1'b0;
			end else begin
				out_q <= 1'b0;
				if (en_q) begin
					if (count_q == '0) begin
						// terminal count
						out_q <= 1'b1;
						if (auto_q) begin
							count_q <= reload_q;
						end else begin
							en_q <= 1'b0;
						end
					end else begin
						count_q <= count_q - 1'b1;
					end
				end
				// bus writes win over the countdown
				if (wr_chan && ofs == `PIT_REG_RELOAD) begin
					reload_q <= reload_nxt;
					count_q  <= reload_nxt;
				end
				if (wr_chan && ofs == `PIT_REG_CTRL && per_i.sel[0]) begin
					en_q   <= per_i.dat[`PIT_CTRL_EN];
					auto_q <= per_i.dat[`PIT_CTRL_AUTO];
				end
			end
		end

		assign reload_r[g]  = reload_q;
		assign count_r[g]   = count_q;
		assign en_r[g]      = en_q;
		assign auto_r[g]    = auto_q;
		assign pit_out_o[g] = out_q;
	end

	// ======================================================================
	// register read and ack
	// ======================================================================
	always_comb begin
		rd_dat = '0;
		// channel 3 reads as zero
		if (chan != 2'd3) begin
			case (ofs)
				`PIT_REG_RELOAD: rd_dat = reload_r[chan];
				`PIT_REG_COUNT:  rd_dat = count_r[chan];
				`PIT_REG_CTRL: begin
					rd_dat[`PIT_CTRL_EN]   = en_r[chan];
					rd_dat[`PIT_CTRL_AUTO] = auto_r[chan];
				end
				default: rd_dat = '0;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i;
		end
	end

	// data captured with the strobe and valid alongside ack
	always_ff @(posedge clk_i) begin
		if (stb_i) begin
			dat_o <= rd_dat;
		end
	end

endmodule

/* mpu_pic.sv */
`timescale 1ns/100ps
`include "mpu_consts.svh"

module mpu_pic import mpu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        stb_i,
	input  per_req_t    per_i,
	input  logic [31:0] src_i,
	output logic        ack_o,
	output dat32_t      dat_o,
	output irq_lvl_t    irq_o,
	output cause_t      cause_o
);

	logic [31:0] src_q;
	logic [31:0] pend_q;
	logic [31:0] en_q;
	logic [31:0] act;
	logic [31:0] clr;
	irq_lvl_t    lvl_q;
	cause_t      cause;
	logic [7:0]  ofs;
	logic        wr;
	dat32_t      wmask;
	dat32_t      rd_dat;

	assign ofs   = per_i.adr[7:0];
	assign wr    = stb_i & per_i.we;
	assign wmask = sel_mask(per_i.sel);

	// write one to clear pending
	assign clr = (wr && ofs == `PIC_REG_PEND) ? (per_i.dat & wmask) : '0;

	// ======================================================================
	// edge detect and registers
	// ======================================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			src_q  <= '0;
			pend_q <= '0;
			en_q   <= '0;
			lvl_q  <= '0;
		end else begin
			src_q <= src_i;
			// a new rising edge sets even if cleared this cycle
			pend_q <= (pend_q & ~clr) | (src_i & ~src_q);
			if (wr && ofs == `PIC_REG_EN) begin
				en_q <= (en_q & ~wmask) | (per_i.dat & wmask);
			end
			if (wr && ofs == `PIC_REG_LVL && per_i.sel[0]) begin
				lvl_q <= per_i.dat[3:0];
			end
		end
	end

	// ======================================================================
	// priority and request out
	// ======================================================================
	assign act = pend_q & en_q;

	// highest numbered active source wins
	// source 0 is never a cause
	always_comb begin
		cause = '0;
		for (int i = 1; i < 32; i++) begin
			if (act[i]) begin
				cause = cause_t'(i);
			end
		end
	end

	assign cause_o = cause;
	assign irq_o   = (|act) ? lvl_q : '0;

	always_comb begin
		case (ofs)
			`PIC_REG_PEND:  rd_dat = pend_q;
			`PIC_REG_EN:    rd_dat = en_q;
			`PIC_REG_LVL:   rd_dat = {28'd0, lvl_q};
			`PIC_REG_CAUSE: rd_dat = {24'd0, cause};
			default:        rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (stb_i) begin
			dat_o <= rd_dat;
		end
	end

endmodule

/* mpu_top.sv */
`timescale 1ns/100ps

module mpu_top import mpu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  bus_req_t    m_req_i,
	output logic        m_ack_o,
	output dat128_t     m_dat_o,
	output bus_req_t    ext_req_o,
	input  logic        ext_ack_i,
	input  dat128_t     ext_dat_i,
	input  logic [27:0] irq_src_i,
	output irq_lvl_t    irq_o,
	output cause_t      cause_o,
	output logic        pit_out2_o
);

	bus_req_t    req;
	per_req_t    per;
	logic        pit_stb;
	logic        pit_ack;
	dat32_t      pit_dat;
	logic        pic_stb;
	logic        pic_ack;
	dat32_t      pic_dat;
	logic [2:0]  pit_out;
	logic [31:0] pic_src;

	// ======================================================================
	// bus side
	// ======================================================================
	mpu_bus_ctrl i_bus_ctrl (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.m_req_i   (m_req_i),
		.m_ack_o   (m_ack_o),
		.m_dat_o   (m_dat_o),
		.ext_req_o (ext_req_o),
		.ext_ack_i (ext_ack_i),
		.ext_dat_i (ext_dat_i),
		.req_o     (req),
		.pit_stb_o (pit_stb),
		.pit_ack_i (pit_ack),
		.pit_dat_i (pit_dat),
		.pic_stb_o (pic_stb),
		.pic_ack_i (pic_ack),
		.pic_dat_i (pic_dat)
	);

	// 128 to 32 bit narrowing
	mpu_lane_steer i_lane_steer (
		.req_i (req),
		.per_o (per)
	);

	// ======================================================================
	// peripherals
	// ======================================================================
	mpu_pit i_pit (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.stb_i     (pit_stb),
		.per_i     (per),
		.ack_o     (pit_ack),
		.dat_o     (pit_dat),
		.pit_out_o (pit_out)
	);

	// timer 0 on 31, timer 1 on 30, timer 2 on 29
	assign pic_src = {pit_out[0], pit_out[1], pit_out[2], irq_src_i, 1'b0};

	mpu_pic i_pic (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stb_i    (pic_stb),
		.per_i    (per),
		.src_i    (pic_src),
		.ack_o    (pic_ack),
		.dat_o    (pic_dat),
		.irq_o    (irq_o),
		.cause_o  (cause_o)
	);

	assign pit_out2_o = pit_out[2];

endmodule

/* tb_mpu.sv */
`timescale 1ns/100ps
`include "mpu_consts.svh"

module tb_mpu import mpu_pkg::*; ();

	localparam int BUS_TIMEOUT   = 50;
	localparam int PULSE_TIMEOUT = 100;

	logic        clk_i;
	logic        arst_n_i;
	bus_req_t    m_req_i;
	logic        m_ack_o;
	dat128_t     m_dat_o;
	bus_req_t    ext_req_o;
	logic        ext_ack_i;
	dat128_t     ext_dat_i;
	logic [27:0] irq_src_i;
	irq_lvl_t    irq_o;
	cause_t      cause_o;
	logic        pit_out2_o;

	integer      seed = 32'h6213;
	int          n_checks;
	int          n_mismatch;
	int          n_timeout;

	// external responder memory and its last answer
	dat128_t     ext_mem [adr_t];
	dat128_t     ext_rsp;

	// reference state of the peripherals
	dat32_t      pit_reload [3];
	logic [2:0]  pit_auto;
	logic [31:0] pend_m;
	logic [31:0] en_m;
	irq_lvl_t    lvl_m;

	mpu_top i_dut (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.m_req_i    (m_req_i),
		.m_ack_o    (m_ack_o),
		.m_dat_o    (m_dat_o),
		.ext_req_o  (ext_req_o),
		.ext_ack_i  (ext_ack_i),
		.ext_dat_i  (ext_dat_i),
		.irq_src_i  (irq_src_i),
		.irq_o      (irq_o),
		.cause_o    (cause_o),
		.pit_out2_o (pit_out2_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ======================================================================
	// helpers
	// ======================================================================
	function automatic dat128_t rand128();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic logic in_window(input adr_t a);
		return (a[31:8] == `MPU_PIT_BASE) || (a[31:8] == `MPU_PIC_BASE);
	endfunction

	// byte selects of one full 32-bit lane
	function automatic sel16_t lane_sel(input logic [1:0] lane);
		return 16'h000F << {lane, 2'b00};
	endfunction

	// highest numbered active source or zero when none
	function automatic cause_t ref_cause(input logic [31:0] act);
		cause_t c;
		c = '0;
		for (int i = 31; i >= 1; i--) begin
			if (act[i] && c == '0) begin
				c = cause_t'(i);
			end
		end
		return c;
	endfunction

	task automatic check_val(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_mismatch++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ======================================================================
	// master access with inline external responder
	// ======================================================================
	task automatic bus_access(input adr_t adr, input sel16_t sel, input logic we,
		input dat128_t wdat, output dat128_t rdat, output int lat);
		int      cycles;
		int      delay;
		logic    acked;
		logic    ext_seen;
		logic    ext_done;
		logic    is_ext;
		dat128_t wr_val;
		cycles   = 0;
		acked    = 1'b0;
		ext_seen = 1'b0;
		ext_done = 1'b0;
		rdat     = '0;
		delay    = {$random(seed)} % 6;
		is_ext   = !in_window(adr);
		m_req_i.cyc = 1'b1;
		m_req_i.stb = 1'b1;
		m_req_i.we  = we;
		m_req_i.sel = sel;
		m_req_i.adr = adr;
		m_req_i.dat = wdat;
		while (!acked && cycles < BUS_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
			// junk on the data bus unless acking
			ext_ack_i = 1'b0;
			ext_dat_i = rand128();
			if (m_ack_o) begin
				acked = 1'b1;
				rdat  = m_dat_o;
			end else if (ext_req_o.cyc && ext_req_o.stb && !ext_done) begin
				if (!ext_seen) begin
					check_val("ext_req_o.adr", ext_req_o.adr, adr);
					check_val("ext_req_o.sel", ext_req_o.sel, sel);
					check_val("ext_req_o.we", ext_req_o.we, we);
					check_val("ext_req_o.dat", ext_req_o.dat, wdat);
					ext_seen = 1'b1;
				end
				if (delay == 0) begin
					// unwritten words follow an address pattern
					if (ext_mem.exists(adr)) begin
						ext_rsp = ext_mem[adr];
					end else begin
						ext_rsp = {adr, ~adr, adr ^ 32'h5A5A5A5A, {adr[15:0], adr[31:16]}};
					end
					if (we) begin
						wr_val = ext_rsp;
						for (int b = 0; b < 16; b++) begin
							if (sel[b]) begin
								wr_val[b*8 +: 8] = wdat[b*8 +: 8];
							end
						end
						ext_mem[adr] = wr_val;
					end
					ext_ack_i = 1'b1;
					ext_dat_i = ext_rsp;
					ext_done  = 1'b1;
				end else begin
					delay--;
				end
			end
		end
		lat       = cycles;
		m_req_i   = '0;
		ext_ack_i = 1'b0;
		if (!acked) begin
			n_timeout++;
			$display("timeout: access to %h got no m_ack_o in %0d cycles", adr, BUS_TIMEOUT);
		end
		check_val("external cycle seen", ext_seen, is_ext);
		// a second ack in these quiet cycles would be a duplicate
		repeat (3) begin
			@(negedge clk_i);
			check_val("m_ack_o", m_ack_o, 1'b0);
			check_val("ext_req_o.cyc", ext_req_o.cyc, 1'b0);
			check_val("ext_req_o.stb", ext_req_o.stb, 1'b0);
		end
	endtask

	// register write on a 16-byte aligned address
	// the lane selects alone carry the word offset
	task automatic reg_write(input logic [23:0] base, input logic [7:0] ofs,
		input dat32_t data);
		dat128_t    wdat;
		dat128_t    rdat;
		int         lat;
		logic [1:0] lane;
		lane = ofs[3:2];
		wdat = rand128();
		wdat[lane*32 +: 32] = data;
		bus_access({base, ofs[7:4], 4'h0}, lane_sel(lane), 1'b1, wdat, rdat, lat);
		check_val("peripheral write latency", lat, 4);
	endtask

	task automatic reg_read(input logic [23:0] base, input logic [7:0] ofs,
		output dat32_t data);
		dat128_t rdat;
		int      lat;
		bus_access({base, ofs[7:4], 4'h0}, lane_sel(ofs[3:2]), 1'b0, rand128(), rdat, lat);
		check_val("peripheral read latency", lat, 4);
		check_val("m_dat_o lane copies", rdat, {4{rdat[31:0]}});
		data = rdat[31:0];
	endtask

	task automatic wait_pulse(output int cycles, output logic seen);
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < PULSE_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
			if (pit_out2_o) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			n_timeout++;
			$display("timeout: pit_out2_o did not pulse in %0d cycles", PULSE_TIMEOUT);
		end
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		dat32_t      d;
		dat32_t      wd;
		dat128_t     rdat;
		int          lat;
		int          cyc_n;
		logic        seen;
		adr_t        pool [4];
		adr_t        a;
		logic [1:0]  ch;
		logic [1:0]  lane;
		logic [27:0] src_new;
		dat32_t      r_val;
		m_req_i    = '0;
		ext_ack_i  = 1'b0;
		ext_dat_i  = '0;
		irq_src_i  = '0;
		arst_n_i   = 1'b0;
		n_checks   = 0;
		n_mismatch = 0;
		n_timeout  = 0;
		pit_reload = '{default: '0};
		pit_auto   = '0;
		pend_m     = '0;
		en_m       = '0;
		lvl_m      = '0;
		repeat (5) @(negedge clk_i);
		arst_n_i = 1'b1;
		@(negedge clk_i);

		// reset state
		check_val("m_ack_o", m_ack_o, 1'b0);
		check_val("irq_o", irq_o, 4'd0);
		check_val("cause_o", cause_o, 8'd0);
		check_val("ext_req_o.cyc", ext_req_o.cyc, 1'b0);
		check_val("ext_req_o.stb", ext_req_o.stb, 1'b0);
		check_val("pit_out2_o", pit_out2_o, 1'b0);
		for (int c = 0; c < 3; c++) begin
			reg_read(`MPU_PIT_BASE, {2'b00, 2'(c), `PIT_REG_RELOAD}, d);
			check_val("pit reload after reset", d, 32'd0);
			reg_read(`MPU_PIT_BASE, {2'b00, 2'(c), `PIT_REG_COUNT}, d);
			check_val("pit count after reset", d, 32'd0);
			reg_read(`MPU_PIT_BASE, {2'b00, 2'(c), `PIT_REG_CTRL}, d);
			check_val("pit ctrl after reset", d, 32'd0);
		end
		reg_read(`MPU_PIC_BASE, `PIC_REG_PEND, d);
		check_val("pic pend after reset", d, 32'd0);
		reg_read(`MPU_PIC_BASE, `PIC_REG_EN, d);
		check_val("pic en after reset", d, 32'd0);
		reg_read(`MPU_PIC_BASE, `PIC_REG_LVL, d);
		check_val("pic lvl after reset", d, 32'd0);
		reg_read(`MPU_PIC_BASE, `PIC_REG_CAUSE, d);
		check_val("pic cause after reset", d, 32'd0);

		// external accesses over a few addresses so reads hit earlier writes
		for (int i = 0; i < 4; i++) begin
			a = $random(seed);
			a[3:0] = 4'h0;
			if (in_window(a)) begin
				a[31] = ~a[31];
			end
			pool[i] = a;
		end
		for (int i = 0; i < 40; i++) begin
			bus_access(pool[{$random(seed)} % 4], 16'($random(seed)), 1'($random(seed)),
				rand128(), rdat, lat);
			check_val("m_dat_o from external", rdat, ext_rsp);
		end

		// timer registers through every lane with all channels stopped
		for (int i = 0; i < 24; i++) begin
			ch   = 2'({$random(seed)} % 3);
			lane = 2'($random(seed));
			wd   = $random(seed);
			if (lane == 2'd2) begin
				wd[`PIT_CTRL_EN] = 1'b0;
				pit_auto[ch] = wd[`PIT_CTRL_AUTO];
			end else if (lane == 2'd0) begin
				pit_reload[ch] = wd;
			end
			reg_write(`MPU_PIT_BASE, {2'b00, ch, lane, 2'b00}, wd);
			reg_read(`MPU_PIT_BASE, {2'b00, ch, `PIT_REG_RELOAD}, d);
			check_val("pit reload", d, pit_reload[ch]);
			reg_read(`MPU_PIT_BASE, {2'b00, ch, `PIT_REG_COUNT}, d);
			check_val("pit count", d, pit_reload[ch]);
			reg_read(`MPU_PIT_BASE, {2'b00, ch, `PIT_REG_CTRL}, d);
			check_val("pit ctrl", d, {30'd0, pit_auto[ch], 1'b0});
		end

		// ==================================================================
		// interrupt controller against the reference model
		// ==================================================================
		lvl_m = 4'({$random(seed)} % 15 + 1);
		en_m  = $random(seed);
		reg_write(`MPU_PIC_BASE, `PIC_REG_EN, en_m);
		reg_write(`MPU_PIC_BASE, `PIC_REG_LVL, {28'd0, lvl_m});
		reg_read(`MPU_PIC_BASE, `PIC_REG_EN, d);
		check_val("pic en", d, en_m);
		reg_read(`MPU_PIC_BASE, `PIC_REG_LVL, d);
		check_val("pic lvl", d, {28'd0, lvl_m});
		for (int i = 0; i < 30; i++) begin
			src_new = 28'($random(seed));
			// sources 1..28 sit one bit up
			pend_m = pend_m | {3'b000, src_new & ~irq_src_i, 1'b0};
			irq_src_i = src_new;
			@(negedge clk_i);
			check_val("irq_o", irq_o, (|(pend_m & en_m)) ? lvl_m : 4'd0);
			check_val("cause_o", cause_o, ref_cause(pend_m & en_m));
			if (i % 5 == 4) begin
				wd = $random(seed);
				reg_write(`MPU_PIC_BASE, `PIC_REG_PEND, wd);
				pend_m = pend_m & ~wd;
				reg_read(`MPU_PIC_BASE, `PIC_REG_PEND, d);
				check_val("pic pend after clear", d, pend_m);
				reg_read(`MPU_PIC_BASE, `PIC_REG_CAUSE, d);
				check_val("pic cause register", d, {24'd0, ref_cause(pend_m & en_m)});
			end
		end
		irq_src_i = '0;
		reg_write(`MPU_PIC_BASE, `PIC_REG_EN, 32'd0);
		reg_write(`MPU_PIC_BASE, `PIC_REG_PEND, 32'hFFFFFFFF);
		en_m   = '0;
		pend_m = '0;

		// timer 2 in auto reload has a period of reload plus one
		r_val = 32'({$random(seed)} % 6 + 3);
		reg_write(`MPU_PIT_BASE, {2'b00, 2'd2, `PIT_REG_RELOAD}, r_val);
		reg_write(`MPU_PIT_BASE, {2'b00, 2'd2, `PIT_REG_CTRL},
			(32'd1 << `PIT_CTRL_EN) | (32'd1 << `PIT_CTRL_AUTO));
		for (int p = 0; p < 4; p++) begin
			wait_pulse(cyc_n, seen);
			if (seen && p > 0) begin
				check_val("pit_out2_o period", cyc_n, r_val + 1);
			end
		end
		reg_read(`MPU_PIC_BASE, `PIC_REG_PEND, d);
		check_val("pic pending bit 29", d[29], 1'b1);
		reg_read(`MPU_PIT_BASE, {2'b00, 2'd2, `PIT_REG_COUNT}, d);
		check_val("pit count not above reload", d <= r_val, 1'b1);
		reg_write(`MPU_PIT_BASE, {2'b00, 2'd2, `PIT_REG_CTRL}, 32'd0);

		$display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_mismatch, n_timeout);
		if (n_mismatch == 0 && n_timeout == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* mpu_top.f */
+incdir+.
mpu_pkg.sv
mpu_bus_ctrl.sv
mpu_lane_steer.sv
mpu_pit.sv
mpu_pic.sv
mpu_top.sv
tb_mpu.sv
